// File: mipsExec.f
verilog/mipsExecPkg.sv
verilog/decodeIf.sv
verilog/aluControl.sv
verilog/alu.sv
verilog/regFile.sv
verilog/wbExecUnit.sv
verilog/mipsExecTop.sv
verif/tbMipsExec.sv

// File: run.sh
#!/bin/sh
# Build and run the execute slice testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f mipsExec.f --top-module tbMipsExec -o simMipsExec
./obj_dir/simMipsExec > sim.log 2>&1
cat sim.log
if grep -q "Testbench passed" sim.log; then
   exit 0
fi
exit 1

// File: verif/tbMipsExec.sv
// Testbench for the MIPS execute slice
// Random instructions over Wishbone, checked against a register model
`timescale 1ns/1ps
`default_nettype none

module tbMipsExec;

   logic        clk;
   logic        arstN;
   logic        wbCyc;
   logic        wbStb;
   logic        wbWe;
   logic [6:0]  wbAdr;
   logic [31:0] wbDatW;
   wire  [31:0] wbDatR;
   wire         wbAck;

   logic [31:0] seed;
   // Register model, r0 never written
   logic [31:0] modelRegs [32];
   logic        modelIllegal;
   logic [31:0] modelAddr;
   int          errCount;
   int          errAtStart;
   int          testsPassed;
   int          testsFailed;

   // R-type functions of the ALU test, constant shifts have their own test
   logic [5:0] rFuncts [13] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h2a, 6'h2b, 6'h24,
                                6'h25, 6'h26, 6'h27, 6'h04, 6'h06, 6'h07};
   // ADDI to LUI
   logic [5:0] iOps [8] = '{6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

   mipsExecTop dut (
      .clk(clk), .arstN(arstN),
      .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
      .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   //*********************************************************************
   // Stimulus source and reference model
   //*********************************************************************
   function automatic logic [31:0] randWord();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic logic isSupported(input logic [31:0] ins);
      if (ins[31:26] == 6'h00)
         return ins[5:0] inside {6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h20, 6'h21,
                                 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
      else
         return ins[31:26] inside {6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f,
                                   6'h23, 6'h2b};
   endfunction

   // Signed compare, differing signs decide directly
   function automatic logic [31:0] lessSigned(input logic [31:0] a, input logic [31:0] b);
      if (a[31] != b[31])
         return {31'd0, a[31]};
      else
         return {31'd0, a < b};
   endfunction

   // Logical shift with the vacated top bits filled by the sign
   function automatic logic [31:0] shiftArith(input logic [31:0] v, input logic [4:0] n);
      logic [31:0] fill;
      fill = v[31] ? ~(32'hffff_ffff >> n) : 32'd0;
      return (v >> n) | fill;
   endfunction

   task automatic modelExec(input logic [31:0] ins);
      logic [5:0]  op;
      logic [5:0]  fn;
      logic [4:0]  sh;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] se;
      logic [31:0] ze;
      logic [31:0] res;
      logic [4:0]  dest;
      logic        wr;
      op   = ins[31:26];
      fn   = ins[5:0];
      sh   = ins[10:6];
      a    = modelRegs[ins[25:21]];
      b    = modelRegs[ins[20:16]];
      se   = {{16{ins[15]}}, ins[15:0]};
      ze   = {16'h0000, ins[15:0]};
      res  = 32'd0;
      dest = ins[20:16];
      wr   = 1'b1;
      if (!isSupported(ins))
      begin
         modelIllegal = 1'b1;
         wr = 1'b0;
      end
      else if (op == 6'h00)
      begin
         dest = ins[15:11];
         case (fn)
            6'h20, 6'h21: res = a + b;
            6'h22, 6'h23: res = a - b;
            6'h2a: res = lessSigned(a, b);
            6'h2b: res = {31'd0, a < b};
            6'h24: res = a & b;
            6'h25: res = a | b;
            6'h26: res = a ^ b;
            6'h27: res = ~(a | b);
            6'h00: res = b << sh;
            6'h02: res = b >> sh;
            6'h03: res = shiftArith(b, sh);
            6'h04: res = b << a[4:0];
            6'h06: res = b >> a[4:0];
            default: res = shiftArith(b, a[4:0]);
         endcase
      end
      else
      begin
         case (op)
            6'h08, 6'h09: res = a + se;
            6'h0a: res = lessSigned(a, se);
            6'h0b: res = {31'd0, a < se};
            6'h0c: res = a & ze;
            6'h0d: res = a | ze;
            6'h0e: res = a ^ ze;
            // LUI ORs the upper immediate into rs
            6'h0f: res = {ins[15:0], 16'h0000} | a;
            // LW and SW only form the address
            default:
            begin
               modelAddr = a + se;
               wr = 1'b0;
            end
         endcase
      end
      if (wr && (dest != 5'd0))
         modelRegs[dest] = res;
   endtask

   //*********************************************************************
   // Wishbone master
   //*********************************************************************
   // Ack and read data are sampled on the falling edge where they are settled
   task automatic busAccess(input logic write, input logic [6:0] adr,
                            input logic [31:0] dat, output logic [31:0] rdat);
      int   cycles;
      logic acked;
      acked = 1'b0;
      rdat  = 32'd0;
      @(posedge clk);
      wbCyc  <= 1'b1;
      wbStb  <= 1'b1;
      wbWe   <= write;
      wbAdr  <= adr;
      wbDatW <= dat;
      for (cycles = 0; (cycles < 20) && !acked; cycles++)
      begin
         @(negedge clk);
         if (wbAck)
         begin
            acked = 1'b1;
            rdat  = wbDatR;
         end
      end
      @(posedge clk);
      wbCyc <= 1'b0;
      wbStb <= 1'b0;
      wbWe  <= 1'b0;
      assert (acked)
      else
      begin
         $display("ERROR at %0t: slave did not acknowledge access to address %0d", $time, adr);
         errCount++;
      end
   endtask

   task automatic wbWrite(input logic [6:0] adr, input logic [31:0] dat);
      logic [31:0] unused;
      busAccess(1'b1, adr, dat, unused);
   endtask

   task automatic wbRead(input logic [6:0] adr, output logic [31:0] dat);
      busAccess(1'b0, adr, 32'd0, dat);
   endtask

   //*********************************************************************
   // Checks and helpers
   //*********************************************************************
   task automatic checkEq(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
      assert (actual === expected)
      else
      begin
         $display("MISMATCH at %0t: %s expected %h actual %h", $time, what, expected, actual);
         errCount++;
      end
   endtask

   task automatic writeReg(input logic [4:0] idx, input logic [31:0] val);
      wbWrite(mipsExecPkg::ADR_REG_BASE | {2'b00, idx}, val);
      if (idx != 5'd0)
         modelRegs[idx] = val;
   endtask

   task automatic checkReg(input logic [4:0] idx);
      logic [31:0] d;
      wbRead(mipsExecPkg::ADR_REG_BASE | {2'b00, idx}, d);
      checkEq($sformatf("r%0d", idx), modelRegs[idx], d);
   endtask

   task automatic checkAllRegs();
      for (int i = 0; i < 32; i++)
         checkReg(5'(i));
   endtask

   task automatic runInstr(input logic [31:0] ins);
      wbWrite(mipsExecPkg::ADR_INSTR, ins);
      modelExec(ins);
   endtask

   task automatic endTest(input string name);
      if (errCount == errAtStart)
      begin
         testsPassed++;
         $display("Test %s: ok", name);
      end
      else
      begin
         testsFailed++;
         $display("Test %s: %0d errors", name, errCount - errAtStart);
      end
      errAtStart = errCount;
   endtask

   // Random word outside the supported set, bounded search
   function automatic logic [31:0] illegalWord();
      logic [31:0] w;
      w = randWord();
      for (int n = 0; (n < 64) && isSupported(w); n++)
         w = randWord();
      return w;
   endfunction

   //*********************************************************************
   // Test sequence
   //*********************************************************************
   initial
   begin
      logic [31:0] r;
      logic [31:0] d;
      logic [5:0]  fn;
      logic [5:0]  op;
      logic [4:0]  rs;
      arstN = 1'b0;
      wbCyc = 1'b0;
      wbStb = 1'b0;
      wbWe = 1'b0;
      wbAdr = 7'd0;
      wbDatW = 32'd0;
      seed = 32'h335e;
      modelIllegal = 1'b0;
      modelAddr = 32'd0;
      errCount = 0;
      errAtStart = 0;
      testsPassed = 0;
      testsFailed = 0;
      for (int i = 0; i < 32; i++)
         modelRegs[i] = 32'd0;
      repeat (10) @(posedge clk);
      arstN <= 1'b1;

      // Reset state, r0 and plain register writes
      checkAllRegs();
      wbRead(mipsExecPkg::ADR_STATUS, d);
      checkEq("status after reset", 32'd0, d);
      wbRead(mipsExecPkg::ADR_ADDR, d);
      checkEq("address after reset", 32'd0, d);
      writeReg(5'd0, randWord());
      checkReg(5'd0);
      for (int i = 1; i < 32; i++)
         writeReg(5'(i), randWord());
      checkAllRegs();
      endTest("reset and r0");

      // R-type ALU, fresh operands before every instruction
      for (int n = 0; n < 200; n++)
      begin
         r  = randWord();
         fn = rFuncts[int'((randWord() >> 16) % 13)];
         writeReg(r[31:27], randWord());
         writeReg(r[26:22], randWord());
         runInstr({6'h00, r[31:27], r[26:22], r[21:17], 5'd0, fn});
         checkReg(r[21:17]);
      end
      endTest("R-type ALU");

      // Immediate ops and LUI, result in rt
      for (int n = 0; n < 200; n++)
      begin
         r  = randWord();
         op = iOps[int'((randWord() >> 16) % 8)];
         rs = (op == 6'h0f) ? 5'd0 : r[31:27];
         writeReg(rs, randWord());
         runInstr({op, rs, r[26:22], 16'(randWord() >> 16)});
         checkReg(r[26:22]);
      end
      endTest("immediate and LUI");

      // Constant shifts by the shamt field
      for (int n = 0; n < 60; n++)
      begin
         r  = randWord();
         fn = (r[11:10] == 2'd0) ? 6'h00 : ((r[11:10] == 2'd1) ? 6'h02 : 6'h03);
         writeReg(r[26:22], randWord());
         runInstr({6'h00, 5'd0, r[26:22], r[21:17], r[16:12], fn});
         checkReg(r[21:17]);
      end
      // SRA of a negative value fills with ones
      writeReg(5'd5, 32'h8000_0000);
      runInstr({6'h00, 5'd0, 5'd5, 5'd6, 5'd4, 6'h03});
      wbRead(mipsExecPkg::ADR_REG_BASE | 7'd6, d);
      checkEq("sra sign fill", 32'hf800_0000, d);
      endTest("constant shifts");

      // LW and SW form an address and leave the registers alone
      for (int n = 0; n < 50; n++)
      begin
         r = randWord();
         writeReg(r[31:27], randWord());
         runInstr({r[12] ? 6'h23 : 6'h2b, r[31:27], r[26:22], 16'(randWord() >> 16)});
         wbRead(mipsExecPkg::ADR_ADDR, d);
         checkEq("effective address", modelAddr, d);
         checkReg(r[26:22]);
         if ((n % 10) == 9)
            checkAllRegs();
      end
      endTest("LW and SW");

      // Illegal encodings set the sticky flag, a status write clears it
      for (int n = 0; n < 30; n++)
      begin
         runInstr(illegalWord());
         wbRead(mipsExecPkg::ADR_STATUS, d);
         checkEq("status after illegal", {31'd0, modelIllegal}, d);
         wbRead(mipsExecPkg::ADR_ADDR, d);
         checkEq("address after illegal", modelAddr, d);
         if ((n % 10) == 0)
            checkAllRegs();
         wbWrite(mipsExecPkg::ADR_STATUS, randWord());
         modelIllegal = 1'b0;
         wbRead(mipsExecPkg::ADR_STATUS, d);
         checkEq("status after clear", 32'd0, d);
      end
      checkAllRegs();
      endTest("illegal encodings");

      $display("Tests run: %0d ok, %0d with errors", testsPassed, testsFailed);
      if ((testsFailed == 0) && (errCount == 0))
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/alu.sv
// 32-bit integer ALU
// Add, sub, compares, logic and shifts, no overflow trap
`timescale 1ns/1ps
`default_nettype none

module alu
(
   input wire [31:0]            opA,
   input wire [31:0]            opB,
   input wire [4:0]             shamt,
   input wire mipsExecPkg::aluSelE sel,
   output logic [31:0]          result
);

   always_comb
   begin
      case (sel)
         // Arithmetic wraps modulo 2^32
         mipsExecPkg::aluAdd:
            result = opA + opB;
         mipsExecPkg::aluSub:
            result = opA - opB;
         // Set on less than, result is 1 or 0
         mipsExecPkg::aluSlt:
            result = {31'd0, $signed(opA) < $signed(opB)};
         mipsExecPkg::aluSltu:
            result = {31'd0, opA < opB};
         mipsExecPkg::aluAnd:
            result = opA & opB;
         mipsExecPkg::aluOr:
            result = opA | opB;
         mipsExecPkg::aluXor:
            result = opA ^ opB;
         mipsExecPkg::aluNor:
            result = ~(opA | opB);
         // Shifts always move opB
         mipsExecPkg::aluSll:
            result = opB << shamt;
         mipsExecPkg::aluSrl:
            result = opB >> shamt;
         // Arithmetic shift, fill with opB[31]
         mipsExecPkg::aluSra:
            result = $unsigned($signed(opB) >>> shamt);
         default:
            result = 32'd0;
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/aluControl.sv
// ALU control block
// Decodes an instruction word into ALU select, operand and writeback controls
`timescale 1ns/1ps
`default_nettype none

module aluControl
(
   input wire [31:0] instr,
   decodeIf.ctrl     dec
);

   mipsExecPkg::opcodeE opcode;
   mipsExecPkg::functE  funct;

   assign opcode = mipsExecPkg::opcodeE'(instr[31:26]);
   assign funct  = mipsExecPkg::functE'(instr[5:0]);

   always_comb
   begin
      // Everything cleared unless a listed encoding matches
      dec.aluSel   = mipsExecPkg::aluAdd;
      dec.useImm   = 1'b0;
      dec.immKind  = mipsExecPkg::immSign;
      dec.destRd   = 1'b0;
      dec.regWrite = 1'b0;
      dec.isMem    = 1'b0;
      dec.varShift = 1'b0;
      dec.illegal  = 1'b0;
      case (opcode)
         mipsExecPkg::opSpecial:
         begin
            // R-type results go to rd
            dec.destRd   = 1'b1;
            dec.regWrite = 1'b1;
            case (funct)
               mipsExecPkg::fnAdd, mipsExecPkg::fnAddu: dec.aluSel = mipsExecPkg::aluAdd;
               mipsExecPkg::fnSub, mipsExecPkg::fnSubu: dec.aluSel = mipsExecPkg::aluSub;
               mipsExecPkg::fnSlt:  dec.aluSel = mipsExecPkg::aluSlt;
               mipsExecPkg::fnSltu: dec.aluSel = mipsExecPkg::aluSltu;
               mipsExecPkg::fnAnd:  dec.aluSel = mipsExecPkg::aluAnd;
               mipsExecPkg::fnOr:   dec.aluSel = mipsExecPkg::aluOr;
               mipsExecPkg::fnXor:  dec.aluSel = mipsExecPkg::aluXor;
               mipsExecPkg::fnNor:  dec.aluSel = mipsExecPkg::aluNor;
               // Constant shifts take the amount from the shamt field
               mipsExecPkg::fnSll:
               begin
                  dec.aluSel  = mipsExecPkg::aluSll;
                  dec.useImm  = 1'b1;
                  dec.immKind = mipsExecPkg::immShamt;
               end
               mipsExecPkg::fnSrl:
               begin
                  dec.aluSel  = mipsExecPkg::aluSrl;
                  dec.useImm  = 1'b1;
                  dec.immKind = mipsExecPkg::immShamt;
               end
               mipsExecPkg::fnSra:
               begin
                  dec.aluSel  = mipsExecPkg::aluSra;
                  dec.useImm  = 1'b1;
                  dec.immKind = mipsExecPkg::immShamt;
               end
               // Variable shifts, amount from rs
               mipsExecPkg::fnSllv:
               begin
                  dec.aluSel   = mipsExecPkg::aluSll;
                  dec.varShift = 1'b1;
               end
               mipsExecPkg::fnSrlv:
               begin
                  dec.aluSel   = mipsExecPkg::aluSrl;
                  dec.varShift = 1'b1;
               end
               mipsExecPkg::fnSrav:
               begin
                  dec.aluSel   = mipsExecPkg::aluSra;
                  dec.varShift = 1'b1;
               end
               default:
               begin
                  dec.destRd   = 1'b0;
                  dec.regWrite = 1'b0;
                  dec.illegal  = 1'b1;
               end
            endcase
         end
         // Immediate ALU ops write rt
         mipsExecPkg::opAddi, mipsExecPkg::opAddiu:
         begin
            dec.useImm   = 1'b1;
            dec.regWrite = 1'b1;
         end
         mipsExecPkg::opSlti:
         begin
            dec.aluSel   = mipsExecPkg::aluSlt;
            dec.useImm   = 1'b1;
            dec.regWrite = 1'b1;
         end
         mipsExecPkg::opSltiu:
         begin
            dec.aluSel   = mipsExecPkg::aluSltu;
            dec.useImm   = 1'b1;
            dec.regWrite = 1'b1;
         end
         // Logic immediates are zero extended
         mipsExecPkg::opAndi:
         begin
            dec.aluSel   = mipsExecPkg::aluAnd;
            dec.useImm   = 1'b1;
            dec.immKind  = mipsExecPkg::immZero;
            dec.regWrite = 1'b1;
         end
         mipsExecPkg::opOri:
         begin
            dec.aluSel   = mipsExecPkg::aluOr;
            dec.useImm   = 1'b1;
            dec.immKind  = mipsExecPkg::immZero;
            dec.regWrite = 1'b1;
         end
         mipsExecPkg::opXori:
         begin
            dec.aluSel   = mipsExecPkg::aluXor;
            dec.useImm   = 1'b1;
            dec.immKind  = mipsExecPkg::immZero;
            dec.regWrite = 1'b1;
         end
         // LUI is rs OR (imm << 16)
         mipsExecPkg::opLui:
         begin
            dec.aluSel   = mipsExecPkg::aluOr;
            dec.useImm   = 1'b1;
            dec.immKind  = mipsExecPkg::immUpper;
            dec.regWrite = 1'b1;
         end
         // No data memory, only the effective address is formed
         mipsExecPkg::opLw, mipsExecPkg::opSw:
         begin
            dec.useImm = 1'b1;
            dec.isMem  = 1'b1;
         end
         default:
            dec.illegal = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/decodeIf.sv
// Decoded instruction controls from the ALU control block to the datapath
`timescale 1ns/1ps
`default_nettype none

interface decodeIf;
   mipsExecPkg::aluSelE  aluSel;
   logic                 useImm;
   mipsExecPkg::immKindE immKind;
   // Write rd rather than rt
   logic                 destRd;
   logic                 regWrite;
   // LW or SW, only the effective address is kept
   logic                 isMem;
   // Shift amount comes from rs[4:0]
   logic                 varShift;
   logic                 illegal;

   modport ctrl (output aluSel, useImm, immKind, destRd, regWrite, isMem, varShift, illegal);
   modport dp (input aluSel, useImm, immKind, destRd, regWrite, isMem, varShift, illegal);
endinterface

`default_nettype wire

// File: verilog/mipsExecPkg.sv
// MIPS execute slice package
// Opcode, function and ALU select encodings, slave states and register map
`default_nettype none

package mipsExecPkg;

   //*********************************************************************
   // Instruction encodings
   //*********************************************************************

   // Primary opcode field, instr[31:26]
   typedef enum logic [5:0] {
      opSpecial = 6'h00,
      opAddi    = 6'h08,
      opAddiu   = 6'h09,
      opSlti    = 6'h0a,
      opSltiu   = 6'h0b,
      opAndi    = 6'h0c,
      opOri     = 6'h0d,
      opXori    = 6'h0e,
      opLui     = 6'h0f,
      opLw      = 6'h23,
      opSw      = 6'h2b
   } opcodeE;

   // SPECIAL function field, instr[5:0]
   typedef enum logic [5:0] {
      fnSll  = 6'h00,
      fnSrl  = 6'h02,
      fnSra  = 6'h03,
      fnSllv = 6'h04,
      fnSrlv = 6'h06,
      fnSrav = 6'h07,
      fnAdd  = 6'h20,
      fnAddu = 6'h21,
      fnSub  = 6'h22,
      fnSubu = 6'h23,
      fnAnd  = 6'h24,
      fnOr   = 6'h25,
      fnXor  = 6'h26,
      fnNor  = 6'h27,
      fnSlt  = 6'h2a,
      fnSltu = 6'h2b
   } functE;

   // ALU operation select
   typedef enum logic [3:0] {
      aluAdd, aluSub, aluSlt, aluSltu, aluAnd, aluOr,
      aluXor, aluNor, aluSll, aluSrl, aluSra
   } aluSelE;

   // Immediate extension kind, immUpper is imm << 16
   typedef enum logic [1:0] {immSign, immZero, immUpper, immShamt} immKindE;

   // Wishbone slave sequencer states
   typedef enum logic [1:0] {stIdle, stExec, stAck} wbStateE;

   //*********************************************************************
   // Register map, word addresses on wbAdr
   //*********************************************************************
   localparam logic [6:0] ADR_INSTR    = 7'd0;
   // Bit 0 is the sticky illegal flag, cleared by any write
   localparam logic [6:0] ADR_STATUS   = 7'd1;
   localparam logic [6:0] ADR_ADDR     = 7'd2;
   // 32..63 map onto r0..r31
   localparam logic [6:0] ADR_REG_BASE = 7'd32;

endpackage

`default_nettype wire

// File: verilog/mipsExecTop.sv
// MIPS integer execute slice behind a Wishbone classic slave port
`timescale 1ns/1ps
`default_nettype none

module mipsExecTop
(
   input wire         clk,
   input wire         arstN,
   input wire         wbCyc,
   input wire         wbStb,
   input wire         wbWe,
   input wire [6:0]   wbAdr,
   input wire [31:0]  wbDatW,
   output wire [31:0] wbDatR,
   output wire        wbAck
);

   logic [31:0]         instr;
   logic [31:0]         aluOpA;
   logic [31:0]         aluOpB;
   logic [4:0]          aluShamt;
   mipsExecPkg::aluSelE aluSel;
   logic [31:0]         aluResult;
   logic [4:0]          raddrA;
   logic [4:0]          raddrB;
   logic [31:0]         rdataA;
   logic [31:0]         rdataB;
   logic                rfWe;
   logic [4:0]          waddr;
   logic [31:0]         wdata;

   // Decoded controls
   decodeIf decBus ();

   wbExecUnit uExec (
      .clk(clk), .arstN(arstN),
      .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
      .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
      .dec(decBus.dp), .instr(instr),
      .aluOpA(aluOpA), .aluOpB(aluOpB), .aluShamt(aluShamt),
      .aluSel(aluSel), .aluResult(aluResult),
      .raddrA(raddrA), .raddrB(raddrB), .rdataA(rdataA), .rdataB(rdataB),
      .rfWe(rfWe), .waddr(waddr), .wdata(wdata)
   );

   aluControl uDecode (.instr(instr), .dec(decBus.ctrl));

   alu uAlu (.opA(aluOpA), .opB(aluOpB), .shamt(aluShamt), .sel(aluSel), .result(aluResult));

   regFile uRegs (
      .clk(clk), .arstN(arstN),
      .raddrA(raddrA), .raddrB(raddrB), .rdataA(rdataA), .rdataB(rdataB),
      .we(rfWe), .waddr(waddr), .wdata(wdata)
   );

endmodule

`default_nettype wire

// File: verilog/regFile.sv
// 32 x 32 register file, two combinational read ports and one write port
// r0 is hardwired to zero
`timescale 1ns/1ps
`default_nettype none

module regFile
(
   input wire         clk,
   input wire         arstN,
   input wire [4:0]   raddrA,
   input wire [4:0]   raddrB,
   output logic [31:0] rdataA,
   output logic [31:0] rdataB,
   input wire         we,
   input wire [4:0]   waddr,
   input wire [31:0]  wdata
);

   // No storage for r0
   logic [31:0] regs [31:1];

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         for (int i = 1; i < 32; i++)
            regs[i] <= 32'd0;
      end
      // Writes to r0 dropped
      else if (we && (waddr != 5'd0))
         regs[waddr] <= wdata;
   end

   assign rdataA = (raddrA == 5'd0) ? 32'd0 : regs[raddrA];
   assign rdataB = (raddrB == 5'd0) ? 32'd0 : regs[raddrB];

endmodule

`default_nettype wire

// File: verilog/wbExecUnit.sv
// Wishbone classic slave and execute sequencer
// Latches instructions, builds ALU operands and writes results back
`timescale 1ns/1ps
`default_nettype none

module wbExecUnit
(
   input wire                       clk,
   input wire                       arstN,
   // Wishbone classic slave
   input wire                       wbCyc,
   input wire                       wbStb,
   input wire                       wbWe,
   input wire [6:0]                 wbAdr,
   input wire [31:0]                wbDatW,
   output logic [31:0]              wbDatR,
   output logic                     wbAck,
   // Decoder and ALU
   decodeIf.dp                      dec,
   output logic [31:0]              instr,
   output logic [31:0]              aluOpA,
   output logic [31:0]              aluOpB,
   output logic [4:0]               aluShamt,
   output mipsExecPkg::aluSelE      aluSel,
   input wire [31:0]                aluResult,
   // Register file
   output logic [4:0]               raddrA,
   output logic [4:0]               raddrB,
   input wire [31:0]                rdataA,
   input wire [31:0]                rdataB,
   output logic                     rfWe,
   output logic [4:0]               waddr,
   output logic [31:0]              wdata
);

   mipsExecPkg::wbStateE state;
   logic [31:0] instrQ;
   logic        illegalQ;
   logic [31:0] addrQ;
   logic [31:0] extImm;
   logic [31:0] readMux;
   logic        hostReq;
   logic        regSpace;
   logic [4:0]  rs;
   logic [4:0]  rt;
   logic [4:0]  rd;

   // Instruction fields
   assign rs = instrQ[25:21];
   assign rt = instrQ[20:16];
   assign rd = instrQ[15:11];

   // New access is only taken in idle
   assign hostReq  = wbCyc && wbStb && (state == mipsExecPkg::stIdle);
   assign regSpace = (wbAdr[6:5] == mipsExecPkg::ADR_REG_BASE[6:5]);
   assign wbAck    = (state == mipsExecPkg::stAck);
   assign instr    = instrQ;

   //*********************************************************************
   // Sequencer, idle -> (exec) -> ack -> idle
   //*********************************************************************
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         state    <= mipsExecPkg::stIdle;
         illegalQ <= 1'b0;
         addrQ    <= 32'd0;
      end
      else
      begin
         case (state)
            mipsExecPkg::stIdle:
               if (hostReq)
               begin
                  if (wbWe && (wbAdr == mipsExecPkg::ADR_INSTR))
                     state <= mipsExecPkg::stExec;
                  else
                     state <= mipsExecPkg::stAck;
                  // Any status write clears the sticky flag
                  if (wbWe && (wbAdr == mipsExecPkg::ADR_STATUS))
                     illegalQ <= 1'b0;
               end
            mipsExecPkg::stExec:
            begin
               state <= mipsExecPkg::stAck;
               if (dec.illegal)
                  illegalQ <= 1'b1;
               if (dec.isMem)
                  addrQ <= aluResult;
            end
            // Ack lasts one cycle, master drops stb or starts anew
            default:
               state <= mipsExecPkg::stIdle;
         endcase
      end
   end

   // Instruction latch and read data, captured when the access is taken
   always_ff @(posedge clk)
   begin
      if (hostReq && wbWe && (wbAdr == mipsExecPkg::ADR_INSTR))
         instrQ <= wbDatW;
      if (hostReq && !wbWe)
         wbDatR <= readMux;
   end

   always_comb
   begin
      case (wbAdr)
         mipsExecPkg::ADR_INSTR:  readMux = instrQ;
         mipsExecPkg::ADR_STATUS: readMux = {31'd0, illegalQ};
         mipsExecPkg::ADR_ADDR:   readMux = addrQ;
         // Register window reads through port A
         default:                 readMux = regSpace ? rdataA : 32'd0;
      endcase
   end

   //*********************************************************************
   // Operand build
   //*********************************************************************
   always_comb
   begin
      case (dec.immKind)
         mipsExecPkg::immSign:  extImm = {{16{instrQ[15]}}, instrQ[15:0]};
         mipsExecPkg::immZero:  extImm = {16'd0, instrQ[15:0]};
         mipsExecPkg::immUpper: extImm = {instrQ[15:0], 16'd0};
         // immShamt, the shamt field
         default:               extImm = {27'd0, instrQ[10:6]};
      endcase
   end

   // Port A is rs in exec, else the host register address
   assign raddrA = (state == mipsExecPkg::stExec) ? rs : wbAdr[4:0];
   assign raddrB = rt;

   assign aluOpA = rdataA;
   // Constant shifts still shift rt, the immediate is only the amount
   assign aluOpB = (dec.useImm && (dec.immKind != mipsExecPkg::immShamt)) ? extImm : rdataB;
   assign aluShamt = dec.varShift ? rdataA[4:0] : extImm[4:0];
   assign aluSel   = dec.aluSel;

   // Write port shared by exec writeback and host register writes
   always_comb
   begin
      if (state == mipsExecPkg::stExec)
      begin
         rfWe  = dec.regWrite;
         waddr = dec.destRd ? rd : rt;
         wdata = aluResult;
      end
      else
      begin
         rfWe  = hostReq && wbWe && regSpace;
         waddr = wbAdr[4:0];
         wdata = wbDatW;
      end
   end

endmodule

`default_nettype wire
